// ==== kcpu_defs.svh ====
// kcpu microcode sequencer
// shared widths and condition code bits

`ifndef KCPU_DEFS_SVH
`define KCPU_DEFS_SVH

// microcode address is {category, row}
`define KCPU_UCODE_AW 10
`define KCPU_OPCAT_AW 6   // 64 routines
`define KCPU_ROW_AW   4   // 16 rows per routine

// condition code register, 6809 layout
// E F H I N Z V C from bit 7 down
`define KCPU_CC_F 6       // FIRQ mask
`define KCPU_CC_I 4       // IRQ mask

`endif

// ==== kcpu_pkg.sv ====
// kcpu sequencer types

`default_nettype none

`include "kcpu_defs.svh"

package kcpu_pkg;

    typedef logic [`KCPU_UCODE_AW-1:0] uaddr_t;
    typedef logic [7:0]                opcode_t;
    typedef logic [3:0]                intvec_t;  // reset, nmi, firq, irq

    // routine categories, interrupt entries first
    typedef enum logic [`KCPU_OPCAT_AW-1:0] {
        RESET          = 6'd0,
        NMI            = 6'd1,
        FIRQ           = 6'd2,
        IRQ            = 6'd3,
        NOPE           = 6'd4,
        SINGLE_ALU     = 6'd5,
        SBRANCH        = 6'd6,
        PARSE_IDX      = 6'd7,
        STORE8         = 6'd8,
        SINGLE_ALU_IDX = 6'd9,
        IDX_R          = 6'd10,
        IDX_OFFSET8    = 6'd11,
        IDX_RINC       = 6'd12,
        IDX_IND        = 6'd13,
        BUSERROR       = 6'd63
    } opcat_t;

    // implemented opcodes
    localparam opcode_t NOP      = 8'h12;
    localparam opcode_t BRA      = 8'h20;
    localparam opcode_t LDA_IMM  = 8'h86;
    localparam opcode_t ADDA_IMM = 8'h8b;
    localparam opcode_t LDA_IDX  = 8'ha6;
    localparam opcode_t STA      = 8'ha7;

    typedef struct packed {
        logic ni;           // next instruction
        logic opd;          // operand fetch
        logic we;
        logic memhi;
        logic up_data;
        logic up_cc;
        logic set_i;
        logic set_f;
        logic int_en;
        logic psh_go;
        logic pul_go;
        logic buserror;
        // used by the sequencer itself
        logic idx_jmp;
        logic idx_ind;
        logic idx_ret;
        logic set_idx_post;
    } ucode_ctrl_t;

    typedef struct packed {
        logic [2:0] rsel;   // index register
        logic [1:0] asel;   // accumulator offset
        logic       ind_rq; // indirect requested
    } idx_sel_t;

endpackage

`default_nettype wire

// ==== kcpu_opcat_dec.sv ====
// opcode to routine category

`timescale 1ns/1ps
`default_nettype none

module kcpu_opcat_dec (
    input  kcpu_pkg::opcode_t op,
    input  kcpu_pkg::opcat_t  post_idx,  // held follow-up category
    output kcpu_pkg::opcat_t  opcat,
    output kcpu_pkg::opcat_t  nx_cat
);
    import kcpu_pkg::*;

    // first routine for the opcode and the one run after index parsing
    always_comb begin
        nx_cat = post_idx;
        case (op)
            NOP: begin
                opcat = NOPE;
            end
            LDA_IMM,
            ADDA_IMM: begin
                opcat = SINGLE_ALU;
            end
            BRA: begin
                opcat = SBRANCH;
            end
            LDA_IDX: begin
                opcat  = PARSE_IDX;
                nx_cat = SINGLE_ALU_IDX;
            end
            STA: begin
                opcat  = PARSE_IDX;
                nx_cat = STORE8;
            end
            default: begin
                opcat = BUSERROR;  // undefined opcode halts the core
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== kcpu_idx_dec.sv ====
// indexed postbyte decoder

`timescale 1ns/1ps
`default_nettype none

module kcpu_idx_dec (
    input  logic [7:0]         postbyte,
    output kcpu_pkg::opcat_t   idx_cat,
    output kcpu_pkg::idx_sel_t idx_sel
);
    import kcpu_pkg::*;

    // mode is bit 7 plus the low three bits
    always_comb begin
        case ({postbyte[7], postbyte[2:0]})
            4'b0_000: idx_cat = IDX_RINC;     // ,r+
            4'b0_100: idx_cat = IDX_OFFSET8;  // n,r
            4'b0_110: idx_cat = IDX_R;        // ,r
            default:  idx_cat = BUSERROR;
        endcase
    end

    assign idx_sel.rsel   = postbyte[6:4];
    assign idx_sel.asel   = postbyte[1:0];
    assign idx_sel.ind_rq = postbyte[3];

endmodule

`default_nettype wire

// ==== kcpu_int_arb.sv ====
// interrupt arbiter, NMI over FIRQ over IRQ

`timescale 1ns/1ps
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_int_arb (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              nmi_n,
    input  logic              firq_n,
    input  logic              irq_n,
    input  logic [7:0]        cc,
    input  logic              take,     // sequencer dispatches this cycle
    input  logic              int_en,
    output logic              intsrv,
    output kcpu_pkg::opcat_t  int_cat,
    output logic              int_pend,
    output kcpu_pkg::intvec_t intvec
);
    import kcpu_pkg::*;

    logic    nmi_l;
    logic    do_nmi;
    logic    firq_ok;
    logic    irq_ok;
    intvec_t win;
    intvec_t cur_int;

    // FIRQ and IRQ are level sensitive
    assign firq_ok = !firq_n && !cc[`KCPU_CC_F];
    assign irq_ok  = !irq_n && !cc[`KCPU_CC_I];

    always_comb begin
        win     = 4'b0000;
        int_cat = RESET;  // don't care while nothing pends
        if (do_nmi) begin
            win     = 4'b0100;
            int_cat = NMI;
        end else if (firq_ok) begin
            win     = 4'b0010;
            int_cat = FIRQ;
        end else if (irq_ok) begin
            win     = 4'b0001;
            int_cat = IRQ;
        end
    end

    assign intsrv   = do_nmi || firq_ok || irq_ok;
    assign int_pend = |win;
    assign intvec   = cur_int & {4{int_en}};

    always_ff @(posedge clk) begin
        if (rst) begin
            nmi_l   <= 1'b0;
            do_nmi  <= 1'b0;
            cur_int <= 4'b1000;
        end else if (cen) begin
            nmi_l <= nmi_n;
            if (!nmi_n && nmi_l) do_nmi <= 1'b1;  // falling edge
            if (take) begin
                cur_int <= win;  // zero when an opcode is taken
                if (win[2]) do_nmi <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== kcpu_ucode_rom.sv ====
// microcode table

`timescale 1ns/1ps
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_ucode_rom (
    input  kcpu_pkg::uaddr_t      addr,
    output kcpu_pkg::ucode_ctrl_t ctrl
);
    import kcpu_pkg::*;

    localparam logic [`KCPU_ROW_AW-1:0] R0 = `KCPU_ROW_AW'd0;
    localparam logic [`KCPU_ROW_AW-1:0] R1 = `KCPU_ROW_AW'd1;

    always_comb begin
        ctrl = '0;
        case (addr)
            {RESET, R0}: begin
                ctrl.int_en = 1'b1;
                ctrl.ni     = 1'b1;
            end
            // interrupt entry, push then fetch
            {NMI, R0},
            {IRQ, R0}: begin
                ctrl.int_en = 1'b1;
                ctrl.psh_go = 1'b1;
                ctrl.set_i  = 1'b1;
            end
            {FIRQ, R0}: begin
                ctrl.int_en = 1'b1;
                ctrl.psh_go = 1'b1;
                ctrl.set_i  = 1'b1;
                ctrl.set_f  = 1'b1;
            end
            {NMI, R1},
            {FIRQ, R1},
            {IRQ, R1},
            {NOPE, R0},
            {SINGLE_ALU, R1},
            {SBRANCH, R1},
            {SINGLE_ALU_IDX, R1},
            {STORE8, R1}: ctrl.ni = 1'b1;
            {SINGLE_ALU, R0}: begin
                ctrl.opd     = 1'b1;
                ctrl.up_data = 1'b1;
            end
            {SBRANCH, R0}: begin
                ctrl.opd     = 1'b1;
                ctrl.up_data = 1'b1;
                ctrl.up_cc   = 1'b1;
            end
            {PARSE_IDX, R0}:      ctrl.idx_jmp      = 1'b1;  // dispatch on postbyte
            {IDX_R, R0},
            {IDX_OFFSET8, R1},
            {IDX_RINC, R1}:       ctrl.idx_ind      = 1'b1;
            {IDX_OFFSET8, R0}:    ctrl.opd          = 1'b1;
            {IDX_RINC, R0}:       ctrl.set_idx_post = 1'b1;
            {IDX_IND, R0}:        ctrl.memhi        = 1'b1;
            {IDX_IND, R1}:        ctrl.idx_ret      = 1'b1;
            {SINGLE_ALU_IDX, R0}: ctrl.up_data      = 1'b1;
            {STORE8, R0}:         ctrl.we           = 1'b1;
            default: begin
                // whole BUSERROR routine halts
                ctrl.buserror = addr[`KCPU_UCODE_AW-1:`KCPU_ROW_AW] == BUSERROR;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== kcpu_useq.sv ====
// microcode address sequencer

`timescale 1ns/1ps
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_useq (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  mem_busy,
    input  logic                  stack_busy,
    input  kcpu_pkg::opcat_t      opcat,
    input  kcpu_pkg::opcat_t      nx_cat,
    input  kcpu_pkg::opcat_t      idx_cat,
    input  kcpu_pkg::opcat_t      int_cat,
    input  logic                  int_pend,
    input  kcpu_pkg::idx_sel_t    idx_sel_in,
    input  kcpu_pkg::ucode_ctrl_t ctrl,
    output kcpu_pkg::uaddr_t      addr,
    output kcpu_pkg::opcat_t      post_idx,
    output logic                  take,
    output kcpu_pkg::idx_sel_t    idx_sel,
    output logic                  idx_post
);
    import kcpu_pkg::*;

    localparam logic [`KCPU_ROW_AW-1:0] ROW0 = '0;

    logic   stall;
    logic   adv;
    logic   nil;        // ni from the previous word
    logic   idx_postl;  // post increment armed
    opcat_t nxt_cat;

    // a busy unit holds the current word, nothing moves
    assign stall   = mem_busy | stack_busy;
    assign adv     = cen & ~ctrl.buserror & ~stall;
    assign take    = adv & nil;
    assign nxt_cat = int_pend ? int_cat : opcat;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr      <= {RESET, ROW0};
            nil       <= 1'b0;
            post_idx  <= RESET;
            idx_sel   <= '0;
            idx_postl <= 1'b0;
            idx_post  <= 1'b0;
        end else if (adv) begin
            nil      <= ctrl.ni;
            post_idx <= nx_cat;
            idx_post <= 1'b0;
            addr     <= addr + 1'b1;  // next row of the routine

            // instruction boundary, interrupts first
            if (nil) addr <= {nxt_cat, ROW0};

            if (ctrl.set_idx_post) idx_postl <= 1'b1;

            if (ctrl.idx_jmp) begin
                addr    <= {idx_cat, ROW0};
                idx_sel <= idx_sel_in;  // postbyte is on mdata now
            end
            if (ctrl.idx_ind) begin
                addr      <= idx_sel.ind_rq ? {IDX_IND, ROW0} : {nx_cat, ROW0};
                idx_post  <= idx_postl;
                idx_postl <= 1'b0;
            end
            if (ctrl.idx_ret) begin
                // back from the indirect fetch
                addr           <= {nx_cat, ROW0};
                idx_sel.ind_rq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== kcpu_ucode_top.sv ====
// microcode sequencer top level

`timescale 1ns/1ps
`default_nettype none

module kcpu_ucode_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  kcpu_pkg::opcode_t     op,
    input  logic [15:0]           mdata,
    input  logic [7:0]            cc,
    input  logic                  mem_busy,
    input  logic                  stack_busy,
    input  logic                  nmi_n,
    input  logic                  firq_n,
    input  logic                  irq_n,
    output kcpu_pkg::ucode_ctrl_t ctrl,
    output kcpu_pkg::idx_sel_t    idx_sel,
    output logic                  idx_post,
    output kcpu_pkg::intvec_t     intvec,
    output logic                  intsrv
);
    import kcpu_pkg::*;

    opcat_t   opcat;
    opcat_t   nx_cat;
    opcat_t   idx_cat;
    opcat_t   int_cat;
    opcat_t   post_idx;
    idx_sel_t idx_dec_sel;
    uaddr_t   addr;
    logic     take;
    logic     int_pend;
    logic     arb_cen;

    assign arb_cen = cen & ~ctrl.buserror;  // arbiter halts with the core

    kcpu_opcat_dec u_opcat_dec (
        .op       (op),
        .post_idx (post_idx),
        .opcat    (opcat),
        .nx_cat   (nx_cat)
    );

    kcpu_idx_dec u_idx_dec (
        .postbyte (mdata[7:0]),
        .idx_cat  (idx_cat),
        .idx_sel  (idx_dec_sel)
    );

    kcpu_int_arb u_int_arb (
        .clk      (clk),
        .rst      (rst),
        .cen      (arb_cen),
        .nmi_n    (nmi_n),
        .firq_n   (firq_n),
        .irq_n    (irq_n),
        .cc       (cc),
        .take     (take),
        .int_en   (ctrl.int_en),
        .intsrv   (intsrv),
        .int_cat  (int_cat),
        .int_pend (int_pend),
        .intvec   (intvec)
    );

    kcpu_ucode_rom u_ucode_rom (
        .addr (addr),
        .ctrl (ctrl)
    );

    kcpu_useq u_useq (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .mem_busy   (mem_busy),
        .stack_busy (stack_busy),
        .opcat      (opcat),
        .nx_cat     (nx_cat),
        .idx_cat    (idx_cat),
        .int_cat    (int_cat),
        .int_pend   (int_pend),
        .idx_sel_in (idx_dec_sel),
        .ctrl       (ctrl),
        .addr       (addr),
        .post_idx   (post_idx),
        .take       (take),
        .idx_sel    (idx_sel),
        .idx_post   (idx_post)
    );

endmodule

`default_nettype wire

// ==== kcpu_assertions.sv ====
// sequencer properties

`timescale 1ns/1ps
`default_nettype none

module kcpu_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic                  mem_busy,
    input logic                  stack_busy,
    input logic                  take,
    input kcpu_pkg::ucode_ctrl_t ctrl,
    input kcpu_pkg::uaddr_t      addr
);
    int fail_cnt = 0;  // read by the testbench

    // busy units hold the microcode address
    hold_on_stall: assert property (@(posedge clk)
        !rst && (mem_busy || stack_busy) |=> $stable(addr))
    else begin
        fail_cnt++;
        $error("microcode address moved during a stall");
    end

    no_take_frozen: assert property (@(posedge clk) disable iff (rst)
        ctrl.buserror |-> !take)
    else begin
        fail_cnt++;
        $error("dispatch while frozen by a bus error");
    end

    no_take_after_rst: assert property (@(posedge clk) rst |=> !take)
    else begin
        fail_cnt++;
        $error("dispatch in the first cycle after reset");
    end

endmodule

bind kcpu_useq kcpu_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .mem_busy   (mem_busy),
    .stack_busy (stack_busy),
    .take       (take),
    .ctrl       (ctrl),
    .addr       (addr)
);

`default_nettype wire

// ==== kcpu_tb.sv ====
// kcpu microcode sequencer testbench

`timescale 1ns/1ps
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_tb;
    import kcpu_pkg::*;

    localparam int NF        = 9;    // words per trace line
    localparam int MAX_VEC   = 128;
    localparam int MAX_STEPS = 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    opcode_t     op;
    logic [15:0] mdata;
    logic [7:0]  cc;
    logic        mem_busy;
    logic        stack_busy;
    logic        nmi_n;
    logic        firq_n;
    logic        irq_n;
    ucode_ctrl_t ctrl;
    idx_sel_t    idx_sel;
    logic        idx_post;
    intvec_t     intvec;
    logic        intsrv;

    logic [31:0] tv [0:NF*MAX_VEC-1];
    int          vi;        // current trace line
    int          n_checks;
    int          n_errs;
    logic        nmi_seen;  // nmi_n as last sampled by the DUT
    logic        nmi_pend;  // latched NMI edge not yet taken

    kcpu_ucode_top DUT (.*);

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errs++;
            $display("CHECK FAILED line %0d %s: got %h expected %h", vi, name, got, exp);
        end
    endtask

    // flags word holds one hex digit per control line
    task automatic apply_vector(input int base);
        logic [31:0] fl;
        fl = tv[base+4];
        op         <= tv[base+1][7:0];
        mdata      <= tv[base+2][15:0];
        cc         <= tv[base+3][7:0];
        rst        <= fl[24];
        cen        <= fl[20];
        mem_busy   <= fl[16];
        stack_busy <= fl[12];
        nmi_n      <= fl[8];
        firq_n     <= fl[4];
        irq_n      <= fl[0];
    endtask

    // any interrupt serviceable with this line's inputs
    function automatic logic expected_intsrv(input int base);
        logic [31:0] fl;
        logic [7:0]  ccv;
        fl  = tv[base+4];
        ccv = tv[base+3][7:0];
        return nmi_pend || (!fl[4] && !ccv[`KCPU_CC_F]) || (!fl[0] && !ccv[`KCPU_CC_I]);
    endfunction

    // NMI edge latch as the coming clock edge updates it
    task automatic track_nmi(input int base);
        logic [31:0] fl;
        fl = tv[base+4];
        if (fl[24]) begin
            nmi_seen = 1'b0;
            nmi_pend = 1'b0;
        end else if (fl[20] && !tv[base+5][4]) begin  // a bus error freezes it
            if (nmi_seen && !fl[8]) nmi_pend = 1'b1;
            nmi_seen = fl[8];
            if (tv[base+NF+8] == 32'h4) nmi_pend = 1'b0;  // NMI entry on the next line
        end
    endtask

    task automatic check_vector(input int base);
        compare_value("ctrl", {16'd0, ctrl}, tv[base+5]);
        compare_value("idx_sel", {26'd0, idx_sel}, tv[base+6]);
        compare_value("idx_post", {31'd0, idx_post}, tv[base+7]);
        compare_value("intvec", {28'd0, intvec}, tv[base+8]);
        compare_value("intsrv", {31'd0, intsrv}, {31'd0, expected_intsrv(base)});
    endtask

    initial begin
        int   fd;
        int   k;
        int   grp;
        int   grp_errs;
        int   steps;
        logic timed_out;
        rst        = 1'b1;
        cen        = 1'b0;
        op         = '0;
        mdata      = '0;
        cc         = 8'h50;  // both masks set
        mem_busy   = 1'b0;
        stack_busy = 1'b0;
        nmi_n      = 1'b1;
        firq_n     = 1'b1;
        irq_n      = 1'b1;
        n_checks   = 0;
        n_errs     = 0;
        vi         = 0;
        steps      = 0;
        timed_out  = 1'b0;
        nmi_seen   = 1'b0;
        nmi_pend   = 1'b0;
        for (k = 0; k < NF*MAX_VEC; k++) tv[k] = '0;  // test 0 marks the end
        fd = $fopen("kcpu_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file kcpu_trace.txt");
            $display("Checks failed");
            $finish;
        end else begin
            $fclose(fd);
            $readmemh("kcpu_trace.txt", tv);
            repeat (3) @(posedge clk);
            grp      = tv[0];
            grp_errs = 0;
            while (tv[vi*NF] != 0 && !timed_out) begin
                if (steps == MAX_STEPS) begin
                    $display("timed out waiting for the end of the trace");
                    timed_out = 1'b1;
                end else begin
                    apply_vector(vi*NF);
                    @(negedge clk);          // outputs settled
                    check_vector(vi*NF);
                    track_nmi(vi*NF);
                    @(posedge clk);
                    vi++;
                    steps++;
                    if (tv[vi*NF] != grp) begin
                        $display("test %0d finished, %0d mismatches", grp, n_errs - grp_errs);
                        grp      = tv[vi*NF];
                        grp_errs = n_errs;
                    end
                end
            end
            $display("%0d checks, %0d mismatches, %0d assertion failures",
                     n_checks, n_errs, DUT.u_useq.u_assertions.fail_cnt);
            if (timed_out || n_errs != 0 || DUT.u_useq.u_assertions.fail_cnt != 0) begin
                $display("Checks failed");
            end else begin
                $display("All checks passed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== kcpu_trace.txt ====
// test op mdata cc flags(rst cen mem_busy stack_busy nmi_n firq_n irq_n, one digit each)
// then expected ctrl idx_sel idx_post intvec
1 12 0000 50 0100111 8080 00 0 8
1 12 0000 50 0100111 0000 00 0 0
1 86 0000 50 0100111 8000 00 0 0
1 86 0000 50 0100111 0000 00 0 0
1 86 0042 50 0100111 4800 00 0 0
1 86 0042 50 0100111 8000 00 0 0
2 12 0000 50 0100111 0000 00 0 0
2 12 0000 50 0110111 8000 00 0 0
2 12 0000 50 0101111 8000 00 0 0
2 12 0000 50 0000111 8000 00 0 0
2 a6 0000 50 0100111 8000 00 0 0
3 a6 0000 50 0100111 0000 00 0 0
3 a6 001c 50 0100111 0008 00 0 0
3 a6 001c 50 0100111 4000 09 0 0
3 a6 001c 50 0100111 0004 09 0 0
3 a6 001c 50 0100111 1000 09 0 0
3 a6 001c 50 0100111 0002 09 0 0
3 a6 001c 50 0100111 0800 08 0 0
3 a6 001c 50 0100111 8000 08 0 0
3 a7 001c 50 0100111 0000 08 0 0
3 a7 0030 50 0100111 0008 08 0 0
3 a7 0030 50 0100111 0001 18 0 0
3 a7 0030 50 0100111 0004 18 0 0
3 a7 0030 50 0100111 2000 18 1 0
4 12 0000 00 0100000 8000 18 0 0
4 12 0000 00 0100000 0000 18 0 0
4 12 0000 00 0100000 02c0 18 0 4
4 12 0000 00 0100000 8000 18 0 0
4 12 0000 00 0100000 0000 18 0 0
4 12 0000 50 0100100 03c0 18 0 2
4 12 0000 50 0100100 8000 18 0 0
4 12 0000 50 0100100 0000 18 0 0
4 12 0000 40 0100100 8000 18 0 0
4 12 0000 40 0100100 0000 18 0 0
4 12 0000 50 0100111 02c0 18 0 1
4 01 0000 50 0100111 8000 18 0 0
5 01 0000 50 0100111 0000 18 0 0
5 12 0024 00 0110000 0010 18 0 0
5 86 0000 00 1100111 0010 18 0 0
5 12 0000 50 0100111 8080 00 0 8

// ==== verilog.f ====
+incdir+.
kcpu_pkg.sv
kcpu_opcat_dec.sv
kcpu_idx_dec.sv
kcpu_int_arb.sv
kcpu_ucode_rom.sv
kcpu_useq.sv
kcpu_ucode_top.sv
kcpu_assertions.sv
kcpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the kcpu testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module kcpu_tb -f verilog.f -o kcpu_sim
./obj_dir/kcpu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "Checks failed" sim.log; then
    exit 1
fi
